// ==== filelist.f ====
+incdir+tests
verilog/health_pkg.sv
verilog/request_ctrl.sv
verilog/risk_eval.sv
verilog/record_update.sv
verilog/verdict_gen.sv
verilog/record_checker.sv
tests/tb_record_checker.sv

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------
// Record fields
function automatic int rec_index(input logic [63:0] rec, input int k);
    case (k)
        0:       return int'(rec[63:52]);
        1:       return int'(rec[51:40]);
        2:       return int'(rec[31:20]);
        default: return int'(rec[19:8]);
    endcase
endfunction

function automatic int formula_value(input logic [63:0] rec, input health_pkg::formula_t f);
    int v [4];
    int lo;
    int hi;
    int total;
    total = 0;
    for (int k = 0; k < 4; k++) begin
        v[k] = rec_index(rec, k);
        total += v[k];
    end
    lo = v[0];
    hi = v[0];
    for (int k = 1; k < 4; k++) begin
        if (v[k] < lo) lo = v[k];
        if (v[k] > hi) hi = v[k];
    end
    case (f)
        health_pkg::Formula_B: return hi - lo;
        health_pkg::Formula_C: return lo;
        default:               return total / 4;
    endcase
endfunction

function automatic int risk_limit(input health_pkg::formula_t f, input health_pkg::mode_t m);
    if (f == health_pkg::Formula_B)
        return (m == health_pkg::Sensitive) ? 200 : (m == health_pkg::Normal) ? 400 : 800;
    return (m == health_pkg::Sensitive) ? 511 : (m == health_pkg::Normal) ? 1023 : 2047;
endfunction

// Signed variation k of the command word, A in the top bits
function automatic int variation(input logic [47:0] vars, input int k);
    logic signed [11:0] s;
    s = vars[(3-k)*12 +: 12];
    return int'(s);
endfunction

function automatic int clamp_index(input int v);
    if (v < 0) return 0;
    if (v > 4095) return 4095;
    return v;
endfunction

function automatic bit any_clamp(input logic [63:0] rec, input logic [47:0] vars);
    int v;
    for (int k = 0; k < 4; k++) begin
        v = rec_index(rec, k) + variation(vars, k);
        if (v != clamp_index(v)) return 1'b1;
    end
    return 1'b0;
endfunction

function automatic logic [63:0] updated_record(input logic [63:0] rec, input logic [47:0] vars,
                                               input int month, input int day);
    logic [11:0] n [4];
    for (int k = 0; k < 4; k++)
        n[k] = 12'(clamp_index(rec_index(rec, k) + variation(vars, k)));
    return {n[0], n[1], 8'(month), n[2], n[3], 8'(day)};
endfunction

function automatic bit date_before(input int cm, input int cd, input logic [63:0] rec);
    int rm;
    int rd;
    rm = int'(rec[39:32]);
    rd = int'(rec[7:0]);
    return (cm < rm) || ((cm == rm) && (cd < rd));
endfunction

`endif

// ==== tests/tb_record_checker.sv ====
`timescale 1ns/1ps

module tb_record_checker;

    localparam logic [31:0] BASE_ADDR = 32'd65536;

    logic                        clk;
    logic                        inf;
    logic                        i_cmd_valid;
    health_pkg::action_t         i_action;
    health_pkg::formula_t        i_formula;
    health_pkg::mode_t           i_mode;
    health_pkg::date_t           i_date;
    logic [7:0]                  i_data_no;
    logic [47:0]                 i_index;
    logic                        i_rd_ready;
    logic                        i_rdata_valid;
    logic [63:0]                 i_rdata;
    logic                        i_wr_ready;
    logic                        i_wr_done;
    logic                        o_rd_valid;
    logic [31:0]                 o_rd_addr;
    logic                        o_rdata_ready;
    logic                        o_wr_valid;
    logic [31:0]                 o_wr_addr;
    logic [63:0]                 o_wr_data;
    logic                        o_out_valid;
    health_pkg::warn_t           o_warn;
    logic                        o_complete;

    logic [63:0] mem [256];
    logic [31:0] stim_state = 32'd37;
    logic [31:0] mem_state  = 32'd37;
    int          cyc = 0;
    int          beat_cyc;
    logic [7:0]  cmd_entry = '0;
    logic [7:0]  rd_entry;
    logic        rdata_pend = 1'b0;
    logic        done_pend = 1'b0;
    logic [1:0]  rd_wait = '0;
    logic [1:0]  rdata_wait;
    logic [1:0]  wr_wait = '0;
    logic [1:0]  done_wait;
    int          wr_count = 0;
    logic [31:0] wr_addr_q;
    logic [63:0] wr_data_q;

    `include "tb_model.svh"

    record_checker #(.BASE_ADDR(BASE_ADDR)) record_checker_i (.*);

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] rand_stim();
        stim_state = lcg(stim_state);
        return stim_state[30:15];
    endfunction

    function automatic logic [15:0] rand_mem();
        mem_state = lcg(mem_state);
        return mem_state[30:15];
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Outputs stay quiet outside the result pulse
    always @(posedge clk) begin
        if (inf && !o_out_valid)
            check("idle_outputs", 64'd0, {o_warn, o_complete});
    end

    // --------------------
    // Memory responder
    always @(posedge clk) begin
        i_rd_ready <= 1'b0;
        i_wr_ready <= 1'b0;
        i_wr_done  <= 1'b0;
        if (o_rd_valid && i_rd_ready) begin
            check("rd_addr", BASE_ADDR + 8 * cmd_entry, o_rd_addr);
            rd_entry   <= 8'((o_rd_addr - BASE_ADDR) >> 3);
            rdata_pend <= 1'b1;
            rdata_wait <= 2'(rand_mem());
        end else if (o_rd_valid) begin
            if (rd_wait == 0) begin
                i_rd_ready <= 1'b1;
                rd_wait    <= 2'(rand_mem());
            end else
                rd_wait <= rd_wait - 2'd1;
        end
        if (o_rdata_ready && i_rdata_valid) begin
            i_rdata_valid <= 1'b0;
            beat_cyc      <= cyc;  // Read-data beat edge
        end else if (rdata_pend) begin
            if (rdata_wait == 0) begin
                i_rdata_valid <= 1'b1;
                i_rdata       <= mem[rd_entry];
                rdata_pend    <= 1'b0;
            end else
                rdata_wait <= rdata_wait - 2'd1;
        end
        if (o_wr_valid && i_wr_ready) begin
            mem[8'((o_wr_addr - BASE_ADDR) >> 3)] <= o_wr_data;
            wr_addr_q <= o_wr_addr;
            wr_data_q <= o_wr_data;
            wr_count  <= wr_count + 1;
            done_pend <= 1'b1;
            done_wait <= 2'(rand_mem());
        end else if (o_wr_valid) begin
            if (wr_wait == 0) begin
                i_wr_ready <= 1'b1;
                wr_wait    <= 2'(rand_mem());
            end else
                wr_wait <= wr_wait - 2'd1;
        end
        if (done_pend) begin
            if (done_wait == 0) begin
                i_wr_done <= 1'b1;
                done_pend <= 1'b0;
            end else
                done_wait <= done_wait - 2'd1;
        end
    end

    // One command beat, then wait for the result pulse
    task automatic run_cmd(input health_pkg::action_t a, input health_pkg::formula_t f,
                           input health_pkg::mode_t m, input int month, input int day,
                           input logic [7:0] entry, input logic [47:0] vars,
                           output health_pkg::warn_t warn, output logic complete,
                           output int latency);
        int n;
        @(posedge clk);
        cmd_entry     = entry;
        i_cmd_valid  <= 1'b1;
        i_action     <= a;
        i_formula    <= f;
        i_mode       <= m;
        i_date.month <= 4'(month);
        i_date.day   <= 5'(day);
        i_data_no    <= entry;
        i_index      <= vars;
        @(posedge clk);
        i_cmd_valid <= 1'b0;
        n = 0;
        while (!o_out_valid) begin
            @(posedge clk);
            n++;
            if (n > 200) begin
                $display("Timeout: o_out_valid never came for entry %0d", entry);
                $display("Simulation finished: FAIL");
                $fatal(1, "Timeout");
            end
        end
        warn     = o_warn;
        complete = o_complete;
        latency  = cyc - beat_cyc;
    endtask

    task automatic index_check(input string name, input logic [7:0] e);
        health_pkg::formula_t f;
        health_pkg::mode_t    m;
        health_pkg::warn_t    w;
        health_pkg::warn_t    exp_w;
        logic                 c;
        int                   lat;
        f = health_pkg::formula_t'(rand_stim() % 3);
        m = health_pkg::mode_t'(rand_stim() % 3);
        exp_w = (formula_value(mem[e], f) >= risk_limit(f, m)) ? health_pkg::Risk_Warn
                                                               : health_pkg::No_Warn;
        run_cmd(health_pkg::Index_Check, f, m, 15, 31, e, '0, w, c, lat);  // Date far ahead
        check(name, exp_w, w);
        check({name, "_complete"}, exp_w == health_pkg::No_Warn, c);
        check({name, "_latency"}, 5, lat);
    endtask

    initial begin
        health_pkg::warn_t w;
        health_pkg::warn_t exp_w;
        logic              c;
        int                lat;
        int                cm;
        int                cd;
        logic [7:0]        e;
        logic [47:0]       vars;
        logic [63:0]       exp_rec;
        i_cmd_valid   = 1'b0;
        i_action      = health_pkg::Index_Check;
        i_formula     = health_pkg::Formula_A;
        i_mode        = health_pkg::Insensitive;
        i_date        = '0;
        i_data_no     = '0;
        i_index       = '0;
        i_rd_ready    = 1'b0;
        i_rdata_valid = 1'b0;
        i_rdata       = '0;
        i_wr_ready    = 1'b0;
        i_wr_done     = 1'b0;
        inf           = 1'b0;
        // Month 2..12 and day 2..28 leave room for an earlier and a later date
        for (int i = 0; i < 256; i++)
            mem[i] = {12'(rand_stim()), 12'(rand_stim()), 8'(2 + rand_stim() % 11),
                      12'(rand_stim()), 12'(rand_stim()), 8'(2 + rand_stim() % 27)};
        repeat (2) @(posedge clk);
        check("reset_outputs", 64'd0,
              {o_rd_valid, o_rdata_ready, o_wr_valid, o_out_valid, o_warn, o_complete});
        inf <= 1'b1;

        // --------------------
        // Index_Check
        for (int t = 0; t < 40; t++)
            index_check("index_check", 8'(rand_stim()));

        // Check_Valid_Date: earlier, equal and later dates
        for (int t = 0; t < 30; t++) begin
            e  = 8'(rand_stim());
            cm = int'(mem[e][39:32]);
            cd = int'(mem[e][7:0]) + (t % 3) - 1;
            exp_w = date_before(cm, cd, mem[e]) ? health_pkg::Date_Warn : health_pkg::No_Warn;
            run_cmd(health_pkg::Check_Valid_Date, health_pkg::Formula_A,
                    health_pkg::Normal, cm, cd, e, '0, w, c, lat);
            check("date_check", exp_w, w);
            check("date_check_complete", exp_w == health_pkg::No_Warn, c);
            check("date_check_latency", 5, lat);
        end

        // --------------------
        // Update then write-back
        for (int t = 0; t < 30; t++) begin
            e    = 8'(rand_stim());
            vars = {12'(rand_stim()), 12'(rand_stim()), 12'(rand_stim()), 12'(rand_stim())};
            if (t % 2 == 0)
                vars = vars & 48'h0ff_0ff_0ff_0ff;  // Smaller steps, fewer clamps
            cm      = 1 + rand_stim() % 12;
            cd      = 1 + rand_stim() % 28;
            exp_rec = updated_record(mem[e], vars, cm, cd);
            exp_w   = any_clamp(mem[e], vars) ? health_pkg::Data_Warn : health_pkg::No_Warn;
            run_cmd(health_pkg::Update, health_pkg::Formula_A, health_pkg::Normal,
                    cm, cd, e, vars, w, c, lat);
            check("update_warn", exp_w, w);
            check("update_complete", exp_w == health_pkg::No_Warn, c);
            check("update_wr_addr", BASE_ADDR + 8 * e, wr_addr_q);
            check("update_wr_data", exp_rec, wr_data_q);
            check("update_mem", exp_rec, mem[e]);
            index_check("write_back", e);
        end

        check("write_count", 64'd30, wr_count);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verilog/record_checker.sv ====
`timescale 1ns/1ps

module record_checker #(
    parameter logic [31:0] BASE_ADDR = 32'd65536
) (
    input  logic                             clk,
    input  logic                             inf,
    input  logic                             i_cmd_valid,
    input  health_pkg::action_t              i_action,
    input  health_pkg::formula_t             i_formula,
    input  health_pkg::mode_t                i_mode,
    input  health_pkg::date_t                i_date,
    input  logic [health_pkg::DATA_NO_W-1:0] i_data_no,
    input  logic [4*health_pkg::IDX_W-1:0]   i_index,
    input  logic                             i_rd_ready,
    input  logic                             i_rdata_valid,
    input  logic [health_pkg::REC_W-1:0]     i_rdata,
    input  logic                             i_wr_ready,
    input  logic                             i_wr_done,
    output logic                             o_rd_valid,
    output logic [31:0]                      o_rd_addr,
    output logic                             o_rdata_ready,
    output logic                             o_wr_valid,
    output logic [31:0]                      o_wr_addr,
    output logic [health_pkg::REC_W-1:0]     o_wr_data,
    output logic                             o_out_valid,
    output health_pkg::warn_t                o_warn,
    output logic                             o_complete
);

    logic [health_pkg::REC_W-1:0]   record;
    logic [health_pkg::REC_W-1:0]   wr_data;
    logic [4*health_pkg::IDX_W-1:0] index;
    health_pkg::formula_t           formula;
    health_pkg::mode_t              mode;
    health_pkg::date_t              date;
    health_pkg::action_t            action;
    logic                           rec_start;
    logic                           finish;
    logic                           risk_flag;
    logic                           data_warn;

    request_ctrl #(
        .BASE_ADDR (BASE_ADDR)
    ) request_ctrl_i (
        .clk           (clk),
        .inf           (inf),
        .i_cmd_valid   (i_cmd_valid),
        .i_action      (i_action),
        .i_formula     (i_formula),
        .i_mode        (i_mode),
        .i_date        (i_date),
        .i_data_no     (i_data_no),
        .i_index       (i_index),
        .i_rd_ready    (i_rd_ready),
        .i_rdata_valid (i_rdata_valid),
        .i_rdata       (i_rdata),
        .i_wr_ready    (i_wr_ready),
        .i_wr_done     (i_wr_done),
        .i_wr_data     (wr_data),
        .o_rd_valid    (o_rd_valid),
        .o_rd_addr     (o_rd_addr),
        .o_rdata_ready (o_rdata_ready),
        .o_wr_valid    (o_wr_valid),
        .o_wr_addr     (o_wr_addr),
        .o_wr_data     (o_wr_data),
        .o_record      (record),
        .o_formula     (formula),
        .o_mode        (mode),
        .o_date        (date),
        .o_index       (index),
        .o_action      (action),
        .o_rec_start   (rec_start),
        .o_finish      (finish)
    );

    risk_eval risk_eval_i (
        .clk         (clk),
        .inf         (inf),
        .i_rec_start (rec_start),
        .i_record    (record),
        .i_formula   (formula),
        .i_mode      (mode),
        .o_risk      (risk_flag)
    );

    record_update record_update_i (
        .clk         (clk),
        .inf         (inf),
        .i_rec_start (rec_start),
        .i_record    (record),
        .i_index     (index),
        .i_date      (date),
        .o_wr_data   (wr_data),
        .o_data_warn (data_warn)
    );

    verdict_gen verdict_gen_i (
        .clk         (clk),
        .inf         (inf),
        .i_finish    (finish),
        .i_action    (action),
        .i_date      (date),
        .i_record    (record),
        .i_risk      (risk_flag),
        .i_data_warn (data_warn),
        .o_out_valid (o_out_valid),
        .o_warn      (o_warn),
        .o_complete  (o_complete)
    );

endmodule

// ==== verilog/verdict_gen.sv ====
`timescale 1ns/1ps

module verdict_gen (
    input  logic                         clk,
    input  logic                         inf,
    input  logic                         i_finish,
    input  health_pkg::action_t          i_action,
    input  health_pkg::date_t            i_date,
    input  logic [health_pkg::REC_W-1:0] i_record,
    input  logic                         i_risk,
    input  logic                         i_data_warn,
    output logic                         o_out_valid,
    output health_pkg::warn_t            o_warn,
    output logic                         o_complete
);

    logic [7:0]        rec_month;
    logic [7:0]        rec_day;
    logic              date_warn;
    health_pkg::warn_t warn;

    assign rec_month = i_record[health_pkg::MONTH_LSB +: health_pkg::DATE_FLD_W];
    assign rec_day   = i_record[health_pkg::DAY_LSB +: health_pkg::DATE_FLD_W];

    // Command date earlier than stored date, month first
    assign date_warn = (8'(i_date.month) < rec_month)
                    || ((8'(i_date.month) == rec_month) && (8'(i_date.day) < rec_day));

    always_comb begin
        case (i_action)
            health_pkg::Index_Check:
                warn = date_warn ? health_pkg::Date_Warn
                     : (i_risk ? health_pkg::Risk_Warn : health_pkg::No_Warn);
            health_pkg::Update:
                warn = i_data_warn ? health_pkg::Data_Warn : health_pkg::No_Warn;
            health_pkg::Check_Valid_Date:
                warn = date_warn ? health_pkg::Date_Warn : health_pkg::No_Warn;
            default: warn = health_pkg::No_Warn;
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            o_out_valid <= 1'b0;
            o_warn      <= health_pkg::No_Warn;
            o_complete  <= 1'b0;
        end else begin
            o_out_valid <= i_finish;
            o_warn      <= i_finish ? warn : health_pkg::No_Warn;
            o_complete  <= i_finish && (warn == health_pkg::No_Warn);
        end
    end

endmodule

// ==== verilog/record_update.sv ====
`timescale 1ns/1ps

module record_update (
    input  logic                           clk,
    input  logic                           inf,
    input  logic                           i_rec_start,
    input  logic [health_pkg::REC_W-1:0]   i_record,
    input  logic [4*health_pkg::IDX_W-1:0] i_index,
    input  health_pkg::date_t              i_date,
    output logic [health_pkg::REC_W-1:0]   o_wr_data,
    output logic                           o_data_warn
);

    localparam int W = health_pkg::IDX_W;

    logic [health_pkg::REC_W-1:0] rec_next;
    logic [3:0]                   clamped;

    always_comb begin
        logic [W+1:0] sum;  // Two guard bits for sign and carry
        logic [W-1:0] delta;
        rec_next = '0;
        for (int i = 0; i < 4; i++) begin
            delta = i_index[(3-i)*W +: W];  // A sits in the top bits
            sum   = {2'b00, i_record[health_pkg::IDX_POS[i] +: W]} + {{2{delta[W-1]}}, delta};
            if (sum[W+1]) begin
                rec_next[health_pkg::IDX_POS[i] +: W] = '0;
                clamped[i] = 1'b1;
            end else if (sum[W]) begin
                rec_next[health_pkg::IDX_POS[i] +: W] = '1;
                clamped[i] = 1'b1;
            end else begin
                rec_next[health_pkg::IDX_POS[i] +: W] = sum[W-1:0];
                clamped[i] = 1'b0;
            end
        end
        rec_next[health_pkg::MONTH_LSB +: health_pkg::DATE_FLD_W] = 8'(i_date.month);
        rec_next[health_pkg::DAY_LSB +: health_pkg::DATE_FLD_W]   = 8'(i_date.day);
    end

    always_ff @(posedge clk) begin
        if (i_rec_start)
            o_wr_data <= rec_next;
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf)
            o_data_warn <= 1'b0;
        else if (i_rec_start)
            o_data_warn <= |clamped;
    end

endmodule

// ==== verilog/risk_eval.sv ====
`timescale 1ns/1ps

module risk_eval (
    input  logic                         clk,
    input  logic                         inf,
    input  logic                         i_rec_start,
    input  logic [health_pkg::REC_W-1:0] i_record,
    input  health_pkg::formula_t         i_formula,
    input  health_pkg::mode_t            i_mode,
    output logic                         o_risk
);

    localparam int W = health_pkg::IDX_W;

    logic [W-1:0] idx [4];
    logic [W-1:0] max_ab;
    logic [W-1:0] min_ab;
    logic [W-1:0] max_cd;
    logic [W-1:0] min_cd;
    logic [W:0]   sum_ab;
    logic [W:0]   sum_cd;
    logic [W-1:0] max_all;
    logic [W-1:0] min_all;
    logic [W+1:0] sum_all;
    logic [W-1:0] result;
    logic [1:0]   vld;

    always_comb begin
        for (int i = 0; i < 4; i++)
            idx[i] = i_record[health_pkg::IDX_POS[i] +: W];
    end

    // --------------------
    // Comparator tree
    always_ff @(posedge clk) begin
        // Stage 1, pairs A/B and C/D
        max_ab  <= (idx[0] >= idx[1]) ? idx[0] : idx[1];
        min_ab  <= (idx[0] >= idx[1]) ? idx[1] : idx[0];
        max_cd  <= (idx[2] >= idx[3]) ? idx[2] : idx[3];
        min_cd  <= (idx[2] >= idx[3]) ? idx[3] : idx[2];
        sum_ab  <= idx[0] + idx[1];
        sum_cd  <= idx[2] + idx[3];
        // Stage 2, overall extremes
        max_all <= (max_ab >= max_cd) ? max_ab : max_cd;
        min_all <= (min_ab <= min_cd) ? min_ab : min_cd;
        sum_all <= sum_ab + sum_cd;
    end

    always_comb begin
        case (i_formula)
            health_pkg::Formula_B: result = max_all - min_all;
            health_pkg::Formula_C: result = min_all;
            default:               result = sum_all[W+1:2];  // Average of four
        endcase
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            vld    <= '0;
            o_risk <= 1'b0;
        end else begin
            vld    <= {vld[0], i_rec_start};
            o_risk <= vld[1] && (result >= health_pkg::risk_threshold(i_formula, i_mode));
        end
    end

    assert property (@(posedge clk) disable iff (!inf)
        $rose(o_risk) |-> $past(i_rec_start, 3))
        else $error("Risk flag rose outside its result slot");

endmodule

// ==== verilog/request_ctrl.sv ====
`timescale 1ns/1ps

module request_ctrl #(
    parameter logic [31:0] BASE_ADDR = 32'd65536
) (
    input  logic                             clk,
    input  logic                             inf,
    input  logic                             i_cmd_valid,
    input  health_pkg::action_t              i_action,
    input  health_pkg::formula_t             i_formula,
    input  health_pkg::mode_t                i_mode,
    input  health_pkg::date_t                i_date,
    input  logic [health_pkg::DATA_NO_W-1:0] i_data_no,
    input  logic [4*health_pkg::IDX_W-1:0]   i_index,
    input  logic                             i_rd_ready,
    input  logic                             i_rdata_valid,
    input  logic [health_pkg::REC_W-1:0]     i_rdata,
    input  logic                             i_wr_ready,
    input  logic                             i_wr_done,
    input  logic [health_pkg::REC_W-1:0]     i_wr_data,
    output logic                             o_rd_valid,
    output logic [31:0]                      o_rd_addr,
    output logic                             o_rdata_ready,
    output logic                             o_wr_valid,
    output logic [31:0]                      o_wr_addr,
    output logic [health_pkg::REC_W-1:0]     o_wr_data,
    output logic [health_pkg::REC_W-1:0]     o_record,
    output health_pkg::formula_t             o_formula,
    output health_pkg::mode_t                o_mode,
    output health_pkg::date_t                o_date,
    output logic [4*health_pkg::IDX_W-1:0]   o_index,
    output health_pkg::action_t              o_action,
    output logic                             o_rec_start,
    output logic                             o_finish
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_DATA,
        S_CALC,
        S_WR_REQ,
        S_WR_RESP
    } state_t;

    state_t      state;
    logic [1:0]  calc_cnt;
    logic [31:0] addr;
    logic        accept;
    logic        rd_beat;

    assign accept  = i_cmd_valid && (state == S_IDLE);
    assign rd_beat = (state == S_RD_DATA) && i_rdata_valid;

    // --------------------
    // FSM
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept)
                        state <= S_RD_REQ;
                end
                S_RD_REQ: begin
                    if (i_rd_ready)
                        state <= S_RD_DATA;
                end
                S_RD_DATA: begin
                    if (i_rdata_valid)
                        state <= S_CALC;
                end
                S_CALC: begin
                    if (o_action == health_pkg::Update)
                        state <= S_WR_REQ;  // Write data is ready next cycle
                    else if (calc_cnt == 2'd2)
                        state <= S_IDLE;
                end
                S_WR_REQ: begin
                    if (i_wr_ready)
                        state <= S_WR_RESP;
                end
                S_WR_RESP: begin
                    if (i_wr_done)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            calc_cnt    <= '0;
            o_rec_start <= 1'b0;
            o_finish    <= 1'b0;
        end else begin
            calc_cnt    <= (state == S_CALC) ? calc_cnt + 2'd1 : 2'd0;
            o_rec_start <= rd_beat;
            // Risk result lands three cycles after rec_start
            o_finish    <= ((state == S_CALC) && (o_action != health_pkg::Update)
                            && (calc_cnt == 2'd2))
                        || ((state == S_WR_RESP) && i_wr_done);
        end
    end

    // --------------------
    // Command and record hold
    always_ff @(posedge clk) begin
        if (accept) begin
            o_action  <= i_action;
            o_formula <= i_formula;
            o_mode    <= i_mode;
            o_date    <= i_date;
            o_index   <= i_index;
            addr      <= BASE_ADDR + 32'({i_data_no, 3'b000});  // 8 bytes per entry
        end
        if (rd_beat)
            o_record <= i_rdata;
    end

    assign o_rd_valid    = (state == S_RD_REQ);
    assign o_rdata_ready = (state == S_RD_DATA);
    assign o_wr_valid    = (state == S_WR_REQ);
    assign o_rd_addr     = addr;
    assign o_wr_addr     = addr;
    assign o_wr_data     = i_wr_data;

    // --------------------
    // Protocol checks
    assert property (@(posedge clk) disable iff (!inf)
        i_cmd_valid |-> (state == S_IDLE) && !o_finish)
        else $error("Command arrived while the checker was busy");

    assert property (@(posedge clk) disable iff (!inf)
        o_rd_valid && !i_rd_ready |=> o_rd_valid && $stable(o_rd_addr))
        else $error("Read request dropped before i_rd_ready");

    assert property (@(posedge clk) disable iff (!inf)
        o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_addr)
                                      && $stable(o_wr_data))
        else $error("Write request dropped before i_wr_ready");

endmodule

// ==== verilog/health_pkg.sv ====
package health_pkg;

    localparam int IDX_W     = 12;
    localparam int REC_W     = 64;
    localparam int DATA_NO_W = 8;

    typedef enum logic [1:0] {
        Index_Check      = 2'd0,
        Update           = 2'd1,
        Check_Valid_Date = 2'd2
    } action_t;

    typedef enum logic [1:0] {
        Formula_A = 2'd0,  // Average
        Formula_B = 2'd1,  // Max - min
        Formula_C = 2'd2   // Minimum
    } formula_t;

    typedef enum logic [1:0] {
        Insensitive = 2'd0,
        Normal      = 2'd1,
        Sensitive   = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        No_Warn   = 2'd0,
        Date_Warn = 2'd1,
        Risk_Warn = 2'd2,
        Data_Warn = 2'd3
    } warn_t;

    typedef struct packed {
        logic [3:0] month;
        logic [4:0] day;
    } date_t;

    // --------------------
    // Record layout
    localparam int IDX_POS [4] = '{52, 40, 20, 8};  // LSBs of A, B, C, D
    localparam int MONTH_LSB   = 32;
    localparam int DAY_LSB     = 0;
    localparam int DATE_FLD_W  = 8;

    function automatic logic [IDX_W-1:0] risk_threshold(formula_t f, mode_t m);
        logic [IDX_W-1:0] base;
        base = (f == Formula_B) ? 12'd800 : 12'd2047;
        case (m)
            Normal:    return base >> 1;
            Sensitive: return base >> 2;
            default:   return base;
        endcase
    endfunction

endpackage
